// File: sim/br_unit_input.txt
# op1 op2 pc imm funct3 is_branch is_jump pred_taken target_hit dest_phy inst_num
# then expected: valid taken mispredict redirect_pc link_we link_data, all hex
# Conditions around signed and unsigned boundaries, correctly predicted
00000005 00000005 00001000 00000040 0 1 0 1 1 00 0001 1 1 0 00001040 0 00000000
80000000 00000000 00001004 00000020 0 1 0 0 0 00 0002 1 0 0 00001008 0 00000000
7fffffff 80000000 00001008 fffffff0 1 1 0 1 1 00 0003 1 1 0 00000ff8 0 00000000
ffffffff ffffffff 0000100c 00000100 1 1 0 0 1 00 0004 1 0 0 00001010 0 00000000
80000000 7fffffff 00001010 00000010 4 1 0 1 1 00 0005 1 1 0 00001020 0 00000000
7fffffff 80000000 00001014 00000080 4 1 0 0 0 00 0006 1 0 0 00001018 0 00000000
ffffffff 00000000 00001018 ffffff00 4 1 0 1 1 00 0007 1 1 0 00000f18 0 00000000
00000000 ffffffff 0000101c 00000008 5 1 0 1 1 00 0008 1 1 0 00001024 0 00000000
80000000 80000001 00001020 00000400 5 1 0 0 1 00 0009 1 0 0 00001024 0 00000000
12345678 12345678 00001024 00000004 5 1 0 1 1 00 000a 1 1 0 00001028 0 00000000
00000000 ffffffff 00001028 00000800 6 1 0 1 1 00 000b 1 1 0 00001828 0 00000000
80000000 7fffffff 0000102c 00000010 6 1 0 0 0 00 000c 1 0 0 00001030 0 00000000
7fffffff 80000000 00001030 fffffffc 6 1 0 1 1 00 000d 1 1 0 0000102c 0 00000000
ffffffff 00000001 00001034 00000030 7 1 0 1 1 00 000e 1 1 0 00001064 0 00000000
00000001 00000002 00001038 00000040 7 1 0 0 0 00 000f 1 0 0 0000103c 0 00000000
00000000 00000000 0000103c 00000200 7 1 0 1 1 00 0010 1 1 0 0000123c 0 00000000
# Mispredicts, each followed by a killed entry, then recovery
0000000a 0000000a 00002000 00000100 0 1 0 0 0 00 0011 1 1 1 00002100 0 00000000
00000001 00000002 00002004 00000040 1 1 0 1 1 00 0012 0 0 0 00000000 0 00000000
00000001 00000002 00002100 00000020 4 1 0 1 1 00 0013 1 1 0 00002120 0 00000000
00000001 00000002 00002124 00000040 7 1 0 1 1 00 0014 1 0 1 00002128 0 00000000
00000000 00000000 00002128 00000100 0 0 1 1 1 12 0015 0 0 0 00000000 0 00000000
00000003 00000004 00003000 00000044 1 1 0 1 0 00 0016 1 1 1 00003044 0 00000000
00000001 00000002 00003004 00000010 0 1 0 1 1 00 0017 0 0 0 00000000 0 00000000
00000005 00000003 00003044 00000010 6 1 0 0 0 00 0018 1 0 0 00003048 0 00000000
# Jumps with link writes
00000001 00000002 00004000 00000800 0 0 1 1 1 21 0019 1 1 0 00004800 1 00004004
00000007 00000007 00004800 fffff000 1 0 1 1 1 3f 001a 1 1 0 00003800 1 00004804
00000000 00000000 00005000 00000100 0 0 1 0 0 05 001b 1 1 1 00005100 1 00005004
00000009 00000009 00005004 00000020 0 1 0 1 1 00 001c 0 0 0 00000000 0 00000000
00000000 00000000 00006000 00000010 0 0 1 1 0 7a 001d 1 1 1 00006010 1 00006004
00000000 00000000 00006004 00000100 0 0 1 1 1 44 001e 0 0 0 00000000 0 00000000
80000000 7fffffff 00007000 00000040 5 1 0 0 0 00 001f 1 0 0 00007004 0 00000000
00000000 00000000 00007004 00000100 0 0 1 1 1 ff 0020 1 1 0 00007104 1 00007008
# Last redirect, then back to back after recovery
00000000 00000000 00008000 00000100 4 1 0 1 1 00 0021 1 0 1 00008004 0 00000000
00000002 00000001 00008004 00000010 7 1 0 1 1 00 0022 0 0 0 00000000 0 00000000
00000000 00000000 00008004 00000008 0 1 0 1 1 00 0023 1 1 0 0000800c 0 00000000
ffffffff fffffffe 0000800c ffffffe0 1 1 0 1 1 00 0024 1 1 0 00007fec 0 00000000

// File: br_unit_top.f
+incdir+design
design/br_pkg.sv
design/br_flag_alu.sv
design/br_stage_buffer.sv
design/br_resolve.sv
design/br_control.sv
design/br_unit_top.sv
sim/br_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --assert --top-module br_unit_tb -f br_unit_top.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vbr_unit_tb > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && { echo "Result: FAIL"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Result: no pass message"; exit 1; }
echo "Result: PASS"

// File: sim/br_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_config.svh"

module br_unit_tb;

    import br_pkg::*;

    // One line of the vector file, all fields widened to 32 bits
    typedef struct packed {
        logic [31:0] operand1;
        logic [31:0] operand2;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] funct3;
        logic [31:0] is_branch;
        logic [31:0] is_jump;
        logic [31:0] pred_taken;
        logic [31:0] target_hit;
        logic [31:0] dest_phy;
        logic [31:0] inst_num;
        logic [31:0] expect_valid;  // 0 for an entry killed by a flush
        logic [31:0] expect_taken;
        logic [31:0] expect_mispredict;
        logic [31:0] expect_redirect_pc;
        logic [31:0] expect_link_we;
        logic [31:0] expect_link_data;
        logic [31:0] issue_step;  // Driver step, for latency
    } vector_t;

    logic       clk = 1'b0;
    logic       reset;
    br_issue_t  issue;
    logic       issue_ready;
    br_result_t result;

    vector_t vec_q[$];  // Loaded from file
    vector_t exp_q[$];  // Issued, waiting for a result
    int      next_vec = 0;
    int      step = 0;
    int      reopen_step = 0;  // First step issue_ready may be high again
    int      cycle_count = 0;
    int      timeout_limit = 0;

    br_unit_top br_unit_top_inst (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .issue_ready (issue_ready),
        .result      (result)
    );

    always #20 clk = ~clk;

    // ****************************************
    // Failure reporting and compare
    // ****************************************

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                     test_name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            report_failure($sformatf("Timeout after %0d cycles, results never arrived",
                                     cycle_count));
        end
    end

    // ****************************************
    // Vector file
    // ****************************************

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        fd = $fopen("sim/br_unit_input.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the vector file sim/br_unit_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    if (line.getc(0) != "#") begin  // Column notes
                        v = '0;
                        n = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v.operand1, v.operand2, v.pc, v.imm, v.funct3,
                            v.is_branch, v.is_jump, v.pred_taken, v.target_hit,
                            v.dest_phy, v.inst_num, v.expect_valid, v.expect_taken,
                            v.expect_mispredict, v.expect_redirect_pc,
                            v.expect_link_we, v.expect_link_data);
                        if (n == 17) begin
                            vec_q.push_back(v);
                        end else if (n > 0) begin
                            report_failure($sformatf("Malformed vector line: %s", line));
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int pending_results();
        int count;
        count = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].expect_valid != 32'd0) begin
                count = count + 1;
            end
        end
        return count;
    endfunction

    // ****************************************
    // Driver and checker
    // ****************************************

    task automatic drive_next(input bit allow_issue);
        vector_t v;
        if (allow_issue && issue_ready && next_vec < vec_q.size()) begin
            v                = vec_q[next_vec];
            v.issue_step     = 32'(step);
            issue.valid      = 1'b1;
            issue.is_branch  = v.is_branch[0];
            issue.is_jump    = v.is_jump[0];
            issue.pred_taken = v.pred_taken[0];
            issue.target_hit = v.target_hit[0];
            issue.dest_phy   = v.dest_phy[`PHY_W-1:0];
            issue.inst_num   = v.inst_num[`INST_NUM_W-1:0];
            issue.pc         = v.pc;
            issue.imm        = v.imm;
            issue.operand1   = v.operand1;
            issue.operand2   = v.operand2;
            issue.funct      = br_funct_e'(v.funct3[2:0]);
            exp_q.push_back(v);
            next_vec = next_vec + 1;
        end else begin
            issue = '0;  // Bubble
        end
    endtask

    task automatic check_result();
        vector_t head;
        string   tag;
        if (result.valid === 1'b1) begin
            // Killed entries never report, drop them once a later one shows up
            while (exp_q.size() != 0 && exp_q[0].expect_valid == 32'd0 &&
                   exp_q[0].inst_num != 32'(result.inst_num)) begin
                void'(exp_q.pop_front());
            end
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Result for inst %0d arrived with nothing pending",
                                         result.inst_num));
            end else begin
                head = exp_q.pop_front();
                tag  = $sformatf("inst %0d", head.inst_num);
                check_value({tag, " valid"}, head.expect_valid, 32'(result.valid));
                check_value({tag, " inst_num"}, head.inst_num, 32'(result.inst_num));
                check_value({tag, " latency"}, 32'd2, 32'(step) - head.issue_step);
                check_value({tag, " taken"}, head.expect_taken, 32'(result.taken));
                check_value({tag, " mispredict"}, head.expect_mispredict,
                            32'(result.mispredict));
                check_value({tag, " redirect_pc"}, head.expect_redirect_pc,
                            32'(result.redirect_pc));
                check_value({tag, " link_we"}, head.expect_link_we, 32'(result.link_we));
                if (head.expect_link_we != 32'd0) begin
                    check_value({tag, " link_data"}, head.expect_link_data,
                                32'(result.link_data));
                    check_value({tag, " link_phy"}, head.dest_phy, 32'(result.link_phy));
                end
                if (result.mispredict) begin
                    reopen_step = step + `RECOVER_CYCLES + 1;  // Flush cycle plus recovery
                end
            end
        end
    endtask

    task automatic run_cycle(input bit allow_issue);
        check_result();
        check_value("issue_ready stall window", (step < reopen_step) ? 32'd0 : 32'd1,
                    32'(issue_ready));
        drive_next(allow_issue);
        @(negedge clk);
        step = step + 1;
    endtask

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        reset = 1'b1;
        issue = '0;
        load_vectors();
        timeout_limit = vec_q.size() * (3 + `RECOVER_CYCLES) + 20;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset result.valid", 32'd0, 32'(result.valid));
        check_value("reset issue_ready", 32'd1, 32'(issue_ready));
        while (next_vec < vec_q.size() || pending_results() != 0) begin
            run_cycle(1'b1);
        end
        repeat (6) begin
            run_cycle(1'b0);  // Quiet tail, nothing more may come out
        end
        if (pending_results() != 0) begin
            report_failure("Run ended with expected results still outstanding");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/br_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module br_unit_top (
    input  wire               clk,
    input  wire               reset,
    input  wire br_pkg::br_issue_t issue,
    output logic              issue_ready,
    output br_pkg::br_result_t result
);

    import br_pkg::*;

    br_flags_t flags;
    br_issue_t buf_issue;
    br_flags_t buf_flags;
    logic      flush;

    // ****************************************
    // Flags, then stage buffer
    // ****************************************

    br_flag_alu u_flag_alu (
        .operand1 (issue.operand1),
        .operand2 (issue.operand2),
        .flags    (flags)
    );

    br_stage_buffer u_stage_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .issue     (issue),
        .flags     (flags),
        .buf_issue (buf_issue),
        .buf_flags (buf_flags)
    );

    // ****************************************
    // Resolve and redirect control
    // ****************************************

    br_resolve u_resolve (
        .clk       (clk),
        .reset     (reset),
        .buf_issue (buf_issue),
        .buf_flags (buf_flags),
        .result    (result)
    );

    br_control u_control (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result.valid),
        .mispredict   (result.mispredict),
        .flush        (flush),
        .issue_ready  (issue_ready)
    );

endmodule

`default_nettype wire

// File: design/br_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_config.svh"

module br_control (
    input  wire  clk,
    input  wire  reset,
    input  wire  result_valid,
    input  wire  mispredict,
    output logic flush,
    output logic issue_ready
);

    import br_pkg::*;

    localparam int CNT_W = $clog2(`RECOVER_CYCLES + 1);

    br_ctrl_state_e   state;
    br_ctrl_state_e   state_next;
    logic [CNT_W-1:0] cnt;
    logic             redirect_hit;

    assign redirect_hit = result_valid && mispredict;

    // ****************************************
    // Redirect and recovery FSM
    // ****************************************

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (redirect_hit) begin
                    state_next = REDIRECT;
                end
            end
            REDIRECT: state_next = RECOVER;
            RECOVER: begin
                if (cnt == CNT_W'(1)) begin
                    state_next = RUN;
                end
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUN;
            cnt   <= '0;
        end else begin
            state <= state_next;
            if (state == REDIRECT) begin
                cnt <= CNT_W'(`RECOVER_CYCLES - 1);  // Redirect cycle is the first stall
            end else if (state == RECOVER) begin
                cnt <= cnt - CNT_W'(1);
            end
        end
    end

    // Flush rises in the cycle the mispredict is visible
    always_comb begin
        case (state)
            RUN:      flush = redirect_hit;
            REDIRECT: flush = 1'b1;
            default:  flush = 1'b0;
        endcase
    end

    assign issue_ready = (state == RUN) && !flush;

    // ****************************************
    // Checks
    // ****************************************

    no_issue_in_recover: assert property (
        @(posedge clk) disable iff (reset)
        (cnt != '0) |-> !issue_ready
    ) else $error("issue opened while the recovery counter was running");

endmodule

`default_nettype wire

// File: design/br_resolve.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_config.svh"

module br_resolve (
    input  wire               clk,
    input  wire               reset,
    input  wire br_pkg::br_issue_t buf_issue,
    input  wire br_pkg::br_flags_t buf_flags,
    output br_pkg::br_result_t result
);

    import br_pkg::*;

    localparam logic [`XLEN-1:0] INST_BYTES = `XLEN'(4);

    logic             cond;
    logic             taken;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] next_pc;
    br_result_t       result_d;

    // ****************************************
    // Condition from funct3
    // ****************************************

    always_comb begin
        case (buf_issue.funct)
            BEQ:     cond = buf_flags.zero;
            BNE:     cond = !buf_flags.zero;
            BLT:     cond = buf_flags.negative != buf_flags.overflow;
            BGE:     cond = buf_flags.negative == buf_flags.overflow;
            BLTU:    cond = !buf_flags.carry;
            BGEU:    cond = buf_flags.carry;
            default: cond = 1'b0;  // Reserved funct3
        endcase
    end

    assign taken   = buf_issue.is_jump || (buf_issue.is_branch && cond);
    assign target  = buf_issue.pc + buf_issue.imm;
    assign next_pc = buf_issue.pc + INST_BYTES;  // Fall-through and link

    always_comb begin
        result_d.valid       = buf_issue.valid;
        result_d.inst_num    = buf_issue.inst_num;
        result_d.taken       = taken;
        // Wrong direction, or taken without a known target
        result_d.mispredict  = (taken != buf_issue.pred_taken) ||
                               (taken && !buf_issue.target_hit);
        result_d.redirect_pc = taken ? target : next_pc;
        result_d.link_phy    = buf_issue.dest_phy;
        result_d.link_we     = buf_issue.valid && buf_issue.is_jump;
        result_d.link_data   = next_pc;
    end

    // ****************************************
    // Result register
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result <= result_d;
        end
    end

    one_kind_per_entry: assert property (
        @(posedge clk) disable iff (reset)
        buf_issue.valid |-> !(buf_issue.is_branch && buf_issue.is_jump)
    ) else $error("issued entry is both a branch and a jump");

endmodule

`default_nettype wire

// File: design/br_stage_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module br_stage_buffer (
    input  wire               clk,
    input  wire               reset,
    input  wire               flush,
    input  wire br_pkg::br_issue_t issue,
    input  wire br_pkg::br_flags_t flags,
    output br_pkg::br_issue_t buf_issue,
    output br_pkg::br_flags_t buf_flags
);

    import br_pkg::*;

    br_issue_t issue_q;
    br_flags_t flags_q;

    // ****************************************
    // Issue plus flags register
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_q.valid <= 1'b0;  // Flush wins over a new load
        end else begin
            issue_q <= issue;
            flags_q <= flags;
        end
    end

    // Entry sitting here under a flush is younger than the mispredict
    always_comb begin
        buf_issue       = issue_q;
        buf_issue.valid = issue_q.valid && !flush;
    end

    assign buf_flags = flags_q;

    // ****************************************
    // Checks
    // ****************************************

    flush_kills_entry: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !buf_issue.valid
    ) else $error("stage buffer entry survived a flush");

endmodule

`default_nettype wire

// File: design/br_flag_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "br_config.svh"

module br_flag_alu (
    input  wire [`XLEN-1:0] operand1,
    input  wire [`XLEN-1:0] operand2,
    output br_pkg::br_flags_t flags
);

    import br_pkg::*;

    logic [`XLEN:0]   sum;  // Carry out on top
    logic [`XLEN-1:0] diff;
    logic             sign_a;
    logic             sign_b;
    logic             sign_d;

    // ****************************************
    // operand1 - operand2 as a + ~b + 1
    // ****************************************

    assign sum  = {1'b0, operand1} + {1'b0, ~operand2} + {{`XLEN{1'b0}}, 1'b1};
    assign diff = sum[`XLEN-1:0];

    assign sign_a = operand1[`XLEN-1];
    assign sign_b = operand2[`XLEN-1];
    assign sign_d = diff[`XLEN-1];

    always_comb begin
        flags.negative = sign_d;
        flags.zero     = (diff == '0);
        // Signs differ and result sign left the minuend's
        flags.overflow = (sign_a != sign_b) && (sign_d != sign_a);
        flags.carry    = sum[`XLEN];  // Clear on unsigned borrow
    end

endmodule

`default_nettype wire

// File: design/br_pkg.sv
`default_nettype none

`include "br_config.svh"

package br_pkg;

    // ****************************************
    // Encodings
    // ****************************************

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_funct_e;  // RV funct3

    typedef enum logic [1:0] {
        RUN      = 2'd0,
        REDIRECT = 2'd1,
        RECOVER  = 2'd2
    } br_ctrl_state_e;

    // ****************************************
    // Stage payloads
    // ****************************************

    typedef struct packed {
        logic                   valid;
        logic                   is_branch;
        logic                   is_jump;
        logic                   pred_taken;  // Predictor direction
        logic                   target_hit;  // Predictor had the target
        logic [`PHY_W-1:0]      dest_phy;
        logic [`INST_NUM_W-1:0] inst_num;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       operand1;
        logic [`XLEN-1:0]       operand2;
        br_funct_e              funct;
    } br_issue_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic overflow;
        logic carry;  // Set means no borrow
    } br_flags_t;

    typedef struct packed {
        logic                   valid;
        logic [`INST_NUM_W-1:0] inst_num;
        logic                   taken;
        logic                   mispredict;
        logic [`XLEN-1:0]       redirect_pc;
        logic [`PHY_W-1:0]      link_phy;
        logic                   link_we;
        logic [`XLEN-1:0]       link_data;
    } br_result_t;

endpackage

`default_nettype wire

// File: design/br_config.svh
`ifndef BR_CONFIG_SVH
`define BR_CONFIG_SVH

// ****************************************
// Branch unit widths
// ****************************************

`define XLEN        32  // Data and PC width
`define PHY_W       8   // Physical register tag
`define INST_NUM_W  32  // Instruction number

// ****************************************
// Recovery
// ****************************************

// Issue stall after a redirect, redirect cycle included, at least 2
`define RECOVER_CYCLES 3

`endif
